//--- rtl/axil_fir_regs.sv
`timescale 1ns/1ps

module axil_fir_regs
	import fir_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	// write address and data
	input  logic [ADDR_W-1:0]   awaddr,
	input  logic                awvalid,
	output logic                awready,
	input  logic [DATA_W-1:0]   wdata,
	input  logic [DATA_W/8-1:0] wstrb,
	input  logic                wvalid,
	output logic                wready,
	output logic [1:0]          bresp,
	output logic                bvalid,
	input  logic                bready,
	// read channels
	input  logic [ADDR_W-1:0]   araddr,
	input  logic                arvalid,
	output logic                arready,
	output logic [DATA_W-1:0]   rdata,
	output logic [1:0]          rresp,
	output logic                rvalid,
	input  logic                rready,
	// filter side
	output logic                sample_valid,
	output logic [SAMPLE_W-1:0] sample,
	output logic                flush,
	output coef_bank_e          bank,
	output logic                pop,
	input  result_t             head,
	input  logic                empty,
	input  logic [COUNT_W-1:0]  count,
	input  logic                almost_full,
	input  logic [FILL_W-1:0]   fill
);

	axil_state_e wr_state;
	axil_state_e rd_state;
	logic        wr_hs;
	logic        wr_stall;
	logic        ar_hs;
	logic [DATA_W-1:0] rd_word;

	// sample writes wait while the FIFO has no room for the pipeline
	assign wr_stall = (awaddr == ADDR_SAMPLE) && almost_full;
	assign wr_hs    = awready && awvalid && wready && wvalid;
	assign ar_hs    = arready && arvalid;

	assign sample_valid = wr_hs && (awaddr == ADDR_SAMPLE) && wstrb[0];
	assign sample       = wdata[SAMPLE_W-1:0];
	assign flush        = wr_hs && (awaddr == ADDR_CTRL);
	assign pop          = ar_hs && (araddr == ADDR_RESULT) && !empty;

	assign bresp = RESP_OKAY;
	assign rresp = RESP_OKAY;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_state <= IDLE;
			awready  <= 1'b0;
			wready   <= 1'b0;
			bvalid   <= 1'b0;
		end
		else
		begin
			case (wr_state)
				IDLE:
				begin
					if (awready)
					begin
						awready  <= 1'b0;
						wready   <= 1'b0;
						bvalid   <= 1'b1;
						wr_state <= RESP;
					end
					else if (awvalid && wvalid && !wr_stall)
					begin
						awready <= 1'b1;
						wready  <= 1'b1;
					end
				end
				RESP:
				begin
					if (bready)
					begin
						bvalid   <= 1'b0;
						wr_state <= IDLE;
					end
				end
				default: wr_state <= IDLE;
			endcase
		end
	end

	// bank register, unknown codes leave it unchanged
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			bank <= BANK_C;
		else if (flush && wstrb[0] && (wdata[2:0] <= BANK_F3))
			bank <= coef_bank_e'(wdata[2:0]);
	end

	always_comb
	begin
		rd_word = '0;
		case (araddr)
			ADDR_CTRL:   rd_word[2:0] = bank;
			ADDR_RESULT:
			begin
				if (!empty)
				begin
					rd_word[DATA_W-1]            = 1'b1;
					rd_word[$bits(result_t)-1:0] = head;
				end
			end
			ADDR_STATUS: rd_word[7:0] = {1'b0, fill, count};
			default:     rd_word = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_state <= IDLE;
			arready  <= 1'b0;
			rvalid   <= 1'b0;
		end
		else
		begin
			case (rd_state)
				IDLE:
				begin
					if (ar_hs)
					begin
						arready  <= 1'b0;
						rvalid   <= 1'b1;
						rd_state <= RESP;
					end
					else if (arvalid)
						arready <= 1'b1;
				end
				RESP:
				begin
					if (rready)
					begin
						rvalid   <= 1'b0;
						rd_state <= IDLE;
					end
				end
				default: rd_state <= IDLE;
			endcase
		end
	end

	// read data is captured with the AR handshake
	always_ff @(posedge clk)
	begin
		if (ar_hs)
			rdata <= rd_word;
	end

	a_bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid);

	// empty and count both come from the FIFO and must agree on every pop
	a_pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> (count != '0));

endmodule

//--- rtl/fir_mac7.sv
`timescale 1ns/1ps

module fir_mac7
	import fir_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       win_valid,
	input  window_t    win,
	input  coef_bank_e bank,
	output logic       res_valid,
	output result_t    res
);

	logic [PROD_W-1:0] prod [NUM_TAPS];
	logic              s1_valid;
	coef_bank_e        s1_bank;
	logic [ACC_W-1:0]  acc;

	// valid bits follow the data through both stages
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			s1_valid  <= 1'b0;
			res_valid <= 1'b0;
		end
		else
		begin
			s1_valid  <= win_valid;
			res_valid <= s1_valid;
		end
	end

	// stage 1, one product per tap
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < NUM_TAPS; i++)
			prod[i] <= win.tap[i] * COEF_TABLE[bank][i];
		s1_bank <= bank;
	end

	// unsigned products, zero extended into the accumulator
	always_comb
	begin
		acc = '0;
		for (int i = 0; i < NUM_TAPS; i++)
			acc = acc + ACC_W'(prod[i]);
	end

	// stage 2
	always_ff @(posedge clk)
	begin
		res.value <= acc[RES_MSB:RES_LSB];
		res.bank  <= s1_bank;
	end

	a_res_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(res_valid));

endmodule

//--- rtl/fir_pkg.sv
package fir_pkg;

	// filter geometry
	localparam int NUM_TAPS = 7;
	localparam int SAMPLE_W = 8;
	localparam int COEF_W   = 9;
	localparam int PROD_W   = SAMPLE_W + COEF_W;
	localparam int ACC_W    = 20;
	localparam int RESULT_W = 16;

	// output slice of the accumulator, top bit unused
	localparam int RES_LSB = 3;
	localparam int RES_MSB = RES_LSB + RESULT_W - 1;

	// result buffering
	localparam int FIFO_DEPTH = 8;
	localparam int PIPE_SLOTS = 3;
	localparam int PTR_W      = $clog2(FIFO_DEPTH);
	localparam int COUNT_W    = PTR_W + 1;
	localparam int FILL_W     = $clog2(NUM_TAPS + 1);

	// register map
	localparam int ADDR_W = 4;
	localparam int DATA_W = 32;
	localparam logic [ADDR_W-1:0] ADDR_CTRL   = 4'h0;
	localparam logic [ADDR_W-1:0] ADDR_SAMPLE = 4'h4;
	localparam logic [ADDR_W-1:0] ADDR_RESULT = 4'h8;
	localparam logic [ADDR_W-1:0] ADDR_STATUS = 4'hC;
	localparam logic [1:0]        RESP_OKAY   = 2'b00;

	typedef enum logic [2:0]
	{
		BANK_B,
		BANK_C,
		BANK_D,
		BANK_1,
		BANK_3,
		BANK_F3
	} coef_bank_e;

	localparam int NUM_BANKS = 6;

	// symmetric sets, tap 0 first
	localparam logic [COEF_W-1:0] COEF_TABLE [NUM_BANKS][NUM_TAPS] = '{
		'{9'd29, 9'd101, 9'd15,  9'd235, 9'd15,  9'd101, 9'd29},
		'{9'd4,  9'd42,  9'd163, 9'd255, 9'd163, 9'd42,  9'd4},
		'{9'd12, 9'd77,  9'd148, 9'd0,   9'd148, 9'd77,  9'd12},
		'{9'd15, 9'd25,  9'd193, 9'd0,   9'd193, 9'd25,  9'd15},
		'{9'd9,  9'd56,  9'd109, 9'd0,   9'd109, 9'd56,  9'd9},
		'{9'd20, 9'd179, 9'd364, 9'd0,   9'd364, 9'd179, 9'd20}
	};

	// tap 0 is the oldest sample and lands in the top byte
	typedef struct packed
	{
		logic [0:NUM_TAPS-1][SAMPLE_W-1:0] tap;
	} window_t;

	// bank sits above the value, same layout as the RESULT register
	typedef struct packed
	{
		coef_bank_e            bank;
		logic [RESULT_W-1:0]   value;
	} result_t;

	typedef enum logic
	{
		IDLE,
		RESP
	} axil_state_e;

endpackage

//--- rtl/fir_top.sv
`timescale 1ns/1ps

module fir_top
	import fir_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic [ADDR_W-1:0]   awaddr,
	input  logic                awvalid,
	output logic                awready,
	input  logic [DATA_W-1:0]   wdata,
	input  logic [DATA_W/8-1:0] wstrb,
	input  logic                wvalid,
	output logic                wready,
	output logic [1:0]          bresp,
	output logic                bvalid,
	input  logic                bready,
	input  logic [ADDR_W-1:0]   araddr,
	input  logic                arvalid,
	output logic                arready,
	output logic [DATA_W-1:0]   rdata,
	output logic [1:0]          rresp,
	output logic                rvalid,
	input  logic                rready
);

	logic                sample_valid;
	logic [SAMPLE_W-1:0] sample;
	logic                flush;
	coef_bank_e          bank;
	logic                win_valid;
	window_t             win;
	logic [FILL_W-1:0]   fill;
	logic                res_valid;
	result_t             res;
	logic                pop;
	result_t             head;
	logic                empty;
	logic [COUNT_W-1:0]  count;
	logic                almost_full;

	axil_fir_regs axil_fir_regs_inst (
		.clk, .rst_n,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.sample_valid, .sample, .flush, .bank,
		.pop, .head, .empty, .count, .almost_full, .fill
	);

	tap_window tap_window_inst (
		.clk, .rst_n, .sample_valid, .sample, .flush, .win_valid, .win, .fill
	);

	fir_mac7 fir_mac7_inst (
		.clk, .rst_n, .win_valid, .win, .bank, .res_valid, .res
	);

	result_fifo result_fifo_inst (
		.clk, .rst_n, .push(res_valid), .din(res), .pop,
		.head, .empty, .count, .almost_full
	);

endmodule

//--- rtl/result_fifo.sv
`timescale 1ns/1ps

module result_fifo
	import fir_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               push,
	input  result_t            din,
	input  logic               pop,
	output result_t            head,
	output logic               empty,
	output logic [COUNT_W-1:0] count,
	output logic               almost_full
);

	result_t          mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             do_pop;

	assign do_pop = pop && !empty;

	// pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= din;
	end

	assign head  = mem[rd_ptr];
	assign empty = (count == '0);
	// leaves room for every result still in the pipeline
	assign almost_full = (count >= COUNT_W'(FIFO_DEPTH - PIPE_SLOTS));

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		push |-> (count != COUNT_W'(FIFO_DEPTH)));

endmodule

//--- rtl/tap_window.sv
`timescale 1ns/1ps

module tap_window
	import fir_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic                sample_valid,
	input  logic [SAMPLE_W-1:0] sample,
	input  logic                flush,
	output logic                win_valid,
	output window_t             win,
	output logic [FILL_W-1:0]   fill
);

	// fill counts accepted samples since the last flush, saturating at seven
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			fill      <= '0;
			win_valid <= 1'b0;
		end
		else
		begin
			win_valid <= 1'b0;
			if (flush)
				fill <= '0;
			else if (sample_valid)
			begin
				if (fill != FILL_W'(NUM_TAPS))
					fill <= fill + 1'b1;
				// this shift completes a full window
				win_valid <= (fill >= FILL_W'(NUM_TAPS - 1));
			end
		end
	end

	// newest sample enters at tap 6, oldest drops off tap 0
	always_ff @(posedge clk)
	begin
		if (sample_valid)
			win.tap <= {win.tap[1:NUM_TAPS-1], sample};
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the FIR testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module tb_fir_top \
	-f verilog.f -o sim_fir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_fir > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$log"; then
	exit 1
fi
exit 0

//--- verification/fir_model.svh
`ifndef FIR_MODEL_SVH
`define FIR_MODEL_SVH

// taps 0 to 3 of each bank, taps 4 to 6 mirror them
localparam int HALF_COEF [6][4] = '{
	'{29, 101, 15, 235},
	'{4, 42, 163, 255},
	'{12, 77, 148, 0},
	'{15, 25, 193, 0},
	'{9, 56, 109, 0},
	'{20, 179, 364, 0}
};

logic [7:0] m_win [7];
int         m_fill;
coef_bank_e m_bank;
result_t    exp_q [$];

function automatic void model_ctrl(input coef_bank_e b);
	m_bank = b;
	m_fill = 0;
endfunction

// oldest sample at index 0
function automatic void model_sample(input logic [7:0] s);
	int unsigned sum;
	result_t     r;
	for (int i = 0; i < 6; i++)
		m_win[i] = m_win[i + 1];
	m_win[6] = s;
	if (m_fill < 7)
		m_fill++;
	if (m_fill < 7)
		return;
	sum = 0;
	for (int i = 0; i < 7; i++)
		sum += m_win[i] * HALF_COEF[int'(m_bank)][(i < 4) ? i : 6 - i];
	// output keeps bits 18 down to 3 of the sum
	r.value = sum[18:3];
	r.bank  = m_bank;
	exp_q.push_back(r);
endfunction

task automatic check_result(input string name, input result_t exp, input result_t act);
	checks++;
	if (act !== exp)
	begin
		errors++;
		$display("Mismatch %s: expected value %0d bank %0d, actual value %0d bank %0d",
			name, exp.value, exp.bank, act.value, act.bank);
	end
endtask

task automatic check_status(input string name, input logic [COUNT_W-1:0] exp_count,
	input logic [FILL_W-1:0] exp_fill, input logic [DATA_W-1:0] word);
	logic [COUNT_W-1:0] act_count;
	logic [FILL_W-1:0]  act_fill;
	act_count = word[COUNT_W-1:0];
	act_fill  = word[COUNT_W +: FILL_W];
	checks++;
	if (act_count !== exp_count || act_fill !== exp_fill)
	begin
		errors++;
		$display("Mismatch %s: expected count %0d fill %0d, actual count %0d fill %0d",
			name, exp_count, exp_fill, act_count, act_fill);
	end
endtask

task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
	checks++;
	if (act !== exp)
	begin
		errors++;
		$display("Mismatch %s: expected response %0d, actual response %0d",
			name, exp, act);
	end
endtask

`endif

//--- verification/tb_fir_top.sv
`timescale 1ns/1ps

module tb_fir_top
	import fir_pkg::*;
();

	localparam int HS_TIMEOUT   = 50;
	localparam int POLL_TIMEOUT = 20;
	localparam int BURST        = FIFO_DEPTH - PIPE_SLOTS;

	logic                clk;
	logic                rst_n;
	logic [ADDR_W-1:0]   awaddr;
	logic                awvalid;
	logic                awready;
	logic [DATA_W-1:0]   wdata;
	logic [DATA_W/8-1:0] wstrb;
	logic                wvalid;
	logic                wready;
	logic [1:0]          bresp;
	logic                bvalid;
	logic                bready;
	logic [ADDR_W-1:0]   araddr;
	logic                arvalid;
	logic                arready;
	logic [DATA_W-1:0]   rdata;
	logic [1:0]          rresp;
	logic                rvalid;
	logic                rready;

	int errors;
	int checks;
	int tests_run;
	int tests_failed;
	bit timed_out;

	`include "fir_model.svh"

	fir_top fir_top_inst (.*);

	always #2 clk = ~clk;

	task automatic report_timeout(input string what);
		errors++;
		timed_out = 1'b1;
		$display("Timeout: %s", what);
	endtask

	// accepted stays low if AW and W were never taken within the limit
	task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		input int limit, output bit accepted);
		int waited;
		accepted = 1'b0;
		if (timed_out)
			return;
		@(negedge clk);
		awaddr  = addr;
		wdata   = data;
		wstrb   = '1;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		waited  = 0;
		while (!(awready && wready) && waited < limit)
		begin
			@(negedge clk);
			waited++;
		end
		if (!(awready && wready))
		begin
			awvalid = 1'b0;
			wvalid  = 1'b0;
			return;
		end
		@(negedge clk);
		awvalid  = 1'b0;
		wvalid   = 1'b0;
		accepted = 1'b1;
		waited   = 0;
		while (!bvalid && waited < HS_TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		if (!bvalid)
		begin
			report_timeout("no write response after the write handshake");
			return;
		end
		check_resp("write response", RESP_OKAY, bresp);
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] word);
		int waited;
		word = '0;
		if (timed_out)
			return;
		@(negedge clk);
		araddr  = addr;
		arvalid = 1'b1;
		waited  = 0;
		while (!arready && waited < HS_TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		arvalid = arready;
		if (!arready)
		begin
			report_timeout("read address was never accepted");
			return;
		end
		@(negedge clk);
		arvalid = 1'b0;
		waited  = 0;
		while (!rvalid && waited < HS_TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		if (!rvalid)
		begin
			report_timeout("no read data after the read handshake");
			return;
		end
		word   = rdata;
		check_resp("read response", RESP_OKAY, rresp);
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic write_sample(input logic [7:0] s, input bit must_accept, output bit accepted);
		axil_write(ADDR_SAMPLE, DATA_W'(s), HS_TIMEOUT, accepted);
		if (accepted)
			model_sample(s);
		else if (must_accept && !timed_out)
			report_timeout("sample write was stalled with room in the FIFO");
	endtask

	task automatic write_bank(input coef_bank_e b);
		bit ok;
		axil_write(ADDR_CTRL, DATA_W'(b), HS_TIMEOUT, ok);
		if (ok)
			model_ctrl(b);
		else if (!timed_out)
			report_timeout("CTRL write was never accepted");
	endtask

	// polls STATUS until a result is waiting, then pops it
	task automatic read_result(input string name);
		logic [DATA_W-1:0] word;
		result_t           exp;
		int                polls;
		exp   = exp_q.pop_front();
		word  = '0;
		polls = 0;
		while (word[COUNT_W-1:0] == 0 && polls < POLL_TIMEOUT && !timed_out)
		begin
			axil_read(ADDR_STATUS, word);
			polls++;
		end
		if (timed_out)
			return;
		if (word[COUNT_W-1:0] == 0)
		begin
			report_timeout("expected result never reached the FIFO");
			return;
		end
		axil_read(ADDR_RESULT, word);
		checks++;
		if (!word[DATA_W-1])
		begin
			errors++;
			$display("%s: RESULT read returned a word without the valid bit", name);
			return;
		end
		check_result(name, exp, result_t'(word[$bits(result_t)-1:0]));
	endtask

	task automatic finish_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start)
			$display("test %s passed", name);
		else
		begin
			tests_failed++;
			$display("test %s failed with %0d errors", name, errors - err_start);
		end
	endtask

	initial
	begin
		bit                ok;
		int                err_start;
		int                attempts;
		logic [DATA_W-1:0] word;
		clk     = 1'b0;
		rst_n   = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		void'($urandom(32'he0ba));
		model_ctrl(BANK_C);
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		err_start = errors;
		axil_read(ADDR_STATUS, word);
		check_status("reset status", '0, '0, word);
		axil_read(ADDR_RESULT, word);
		checks++;
		if (word !== '0)
		begin
			errors++;
			$display("reset: RESULT read from the empty FIFO returned %h, not zero", word);
		end
		finish_test("reset", err_start);

		err_start = errors;
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			write_bank(coef_bank_e'(b));
			for (int n = 0; n < 20; n++)
			begin
				write_sample(8'($urandom), 1'b1, ok);
				if (exp_q.size() > 0)
					read_result($sformatf("bank %0d", b));
			end
		end
		finish_test("bank_sweep", err_start);

		// switch bank with a full window, nothing may come out during the refill
		err_start = errors;
		for (int n = 0; n < 3; n++)
		begin
			write_sample(8'($urandom), 1'b1, ok);
			if (exp_q.size() > 0)
				read_result("flush lead-in");
		end
		write_bank(BANK_D);
		for (int n = 0; n < NUM_TAPS; n++)
		begin
			axil_read(ADDR_STATUS, word);
			check_status("flush refill", COUNT_W'(exp_q.size()), FILL_W'(m_fill), word);
			write_sample(8'($urandom), 1'b1, ok);
		end
		while (exp_q.size() > 0)
			read_result("flush first window");
		finish_test("flush", err_start);

		err_start = errors;
		ok        = 1'b1;
		attempts  = 0;
		while (ok && attempts < 2 * FIFO_DEPTH && !timed_out)
		begin
			write_sample(8'($urandom), 1'b0, ok);
			attempts++;
		end
		checks++;
		if (ok)
		begin
			errors++;
			$display("backpressure: sample writes were never stalled");
		end
		axil_read(ADDR_STATUS, word);
		checks++;
		if (int'(word[COUNT_W-1:0]) > FIFO_DEPTH)
		begin
			errors++;
			$display("backpressure: FIFO count %0d is above its depth", word[COUNT_W-1:0]);
		end
		check_status("backpressure status", COUNT_W'(exp_q.size()), FILL_W'(m_fill), word);
		while (exp_q.size() > 0)
			read_result("backpressure drain");
		finish_test("backpressure", err_start);

		err_start = errors;
		for (int r = 0; r < 4; r++)
		begin
			for (int n = 0; n < BURST; n++)
				write_sample(8'($urandom), 1'b1, ok);
			while (exp_q.size() > 0)
				read_result($sformatf("pipeline round %0d", r));
		end
		finish_test("pipeline", err_start);

		$display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+verification
rtl/fir_pkg.sv
rtl/result_fifo.sv
rtl/tap_window.sv
rtl/fir_mac7.sv
rtl/axil_fir_regs.sv
rtl/fir_top.sv
verification/tb_fir_top.sv
